/* Bender.yml */
package:
  name: nr_sss

sources:
  - nr_sss_pkg.sv
  - mseq_lfsr.sv
  - sss_capture.sv
  - sss_correlator.sv
  - nr_sss_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_nr_sss_top.sv

/* mseq_lfsr.sv */
`timescale 1ns/1ps
`default_nettype none

module mseq_lfsr #(
    parameter int unsigned       LFSR_N      = 7,
    parameter logic [LFSR_N-1:0] TAPS        = 'h11,
    parameter logic [LFSR_N-1:0] START_VALUE = 'h01
) (
    input  logic clk_i,
    input  logic reset_ni,
    output logic seq_bit_o,
    output logic seq_valid_o
);

    // one full period of a maximal length sequence is 2^N - 1 bits
    localparam logic [LFSR_N-1:0] LAST_CNT = {LFSR_N{1'b1}};

    // reg_q[0] is x(i), reg_q[LFSR_N-1] is x(i+LFSR_N-1)
    logic [LFSR_N-1:0] reg_q;
    logic [LFSR_N-1:0] cnt_q;
    logic              feedback;

    // x(i+N) is the xor of the tapped positions
    assign feedback    = ^(reg_q & TAPS);
    assign seq_bit_o   = reg_q[0];
    assign seq_valid_o = (cnt_q != LAST_CNT);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            reg_q <= START_VALUE;
            cnt_q <= '0;
        end else if (seq_valid_o) begin
            // new bit enters at the top, oldest leaves at bit 0
            reg_q <= {feedback, reg_q[LFSR_N-1:1]};
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // once the period is out the register holds its state

endmodule

`default_nettype wire

/* nr_sss.f */
+incdir+.
nr_sss_pkg.sv
mseq_lfsr.sv
sss_capture.sv
sss_correlator.sv
nr_sss_top.sv
tb_nr_sss_top.sv

/* nr_sss_pkg.sv */
`default_nettype none

package nr_sss_pkg;

    // length of the SSS and of both m-sequences
    localparam int unsigned SSS_LEN = 127;

    // N_id_1 runs over 0..335
    localparam int unsigned N_ID_1_MAX = 335;
    localparam int unsigned N_ID_1_W   = 9;

    // N_id = 3*N_id_1 + N_id_2, at most 1007
    localparam int unsigned N_ID_W = 10;

    // m1 shifts per m0 group
    localparam int unsigned SHIFT_GROUP = 112;

    // bit n holds symbol n, 1 for +1 and 0 for -1
    typedef struct packed {
        logic [SSS_LEN-1:0] bits;
    } sss_frame_t;

    typedef struct packed {
        logic [N_ID_1_W-1:0] n_id_1;
        logic [N_ID_W-1:0]   n_id;
    } sss_result_t;

    // load waits for a frame, search walks all hypotheses,
    // report hands the best one to the output
    typedef enum logic [1:0] {
        SSS_LOAD,
        SSS_SEARCH,
        SSS_REPORT
    } sss_state_e;

endpackage

`default_nettype wire

/* nr_sss_top.sv */
`timescale 1ns/1ps
`default_nettype none

module nr_sss_top #(
    parameter int unsigned       LFSR_N      = 7,
    // x0(i+7) = x0(i+4) + x0(i), x1(i+7) = x1(i+1) + x1(i)
    parameter logic [LFSR_N-1:0] SEQ0_TAPS   = 'h11,
    parameter logic [LFSR_N-1:0] SEQ1_TAPS   = 'h03,
    parameter logic [LFSR_N-1:0] START_VALUE = 'h01
) (
    input  logic                    clk_i,
    input  logic                    reset_ni,
    input  logic                    sss_bit_i,
    input  logic                    sss_valid_i,
    input  logic [1:0]              n_id_2_i,
    input  logic                    n_id_2_valid_i,
    output nr_sss_pkg::sss_result_t result_o,
    output logic                    result_valid_o
);

    import nr_sss_pkg::*;

    logic       seq0_bit;
    logic       seq0_valid;
    logic       seq1_bit;
    logic       seq1_valid;
    sss_frame_t frame;
    logic       frame_valid;
    logic       busy;

    mseq_lfsr #(
        .LFSR_N     (LFSR_N),
        .TAPS       (SEQ0_TAPS),
        .START_VALUE(START_VALUE)
    ) seq0_lfsr (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .seq_bit_o  (seq0_bit),
        .seq_valid_o(seq0_valid)
    );

    mseq_lfsr #(
        .LFSR_N     (LFSR_N),
        .TAPS       (SEQ1_TAPS),
        .START_VALUE(START_VALUE)
    ) seq1_lfsr (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .seq_bit_o  (seq1_bit),
        .seq_valid_o(seq1_valid)
    );

    sss_capture capture0 (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .sss_bit_i    (sss_bit_i),
        .sss_valid_i  (sss_valid_i),
        .busy_i       (busy),
        .frame_o      (frame),
        .frame_valid_o(frame_valid)
    );

    sss_correlator correlator0 (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .seq0_bit_i    (seq0_bit),
        .seq0_valid_i  (seq0_valid),
        .seq1_bit_i    (seq1_bit),
        .seq1_valid_i  (seq1_valid),
        .frame_i       (frame),
        .frame_valid_i (frame_valid),
        .n_id_2_i      (n_id_2_i),
        .n_id_2_valid_i(n_id_2_valid_i),
        .busy_o        (busy),
        .result_o      (result_o),
        .result_valid_o(result_valid_o)
    );

endmodule

`default_nettype wire

/* sss_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module sss_capture (
    input  logic                   clk_i,
    input  logic                   reset_ni,
    input  logic                   sss_bit_i,
    input  logic                   sss_valid_i,
    input  logic                   busy_i,
    output nr_sss_pkg::sss_frame_t frame_o,
    output logic                   frame_valid_o
);

    import nr_sss_pkg::*;

    localparam int unsigned      CNT_W    = $clog2(SSS_LEN);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SSS_LEN - 1);

    sss_frame_t       frame_q;
    logic [CNT_W-1:0] cnt_q;
    logic             frame_valid_q;
    logic             accept;

    // input bits are dropped while the correlator searches
    assign accept        = sss_valid_i && !busy_i;
    assign frame_o       = frame_q;
    assign frame_valid_o = frame_valid_q;

    // bit n of the frame is the n-th accepted bit
    always_ff @(posedge clk_i) begin
        if (accept) begin
            frame_q.bits[cnt_q] <= sss_bit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cnt_q         <= '0;
            frame_valid_q <= 1'b0;
        end else begin
            frame_valid_q <= 1'b0;
            if (accept) begin
                if (cnt_q == CNT_LAST) begin
                    // last position written, frame is complete
                    cnt_q         <= '0;
                    frame_valid_q <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sss_correlator.sv */
`timescale 1ns/1ps
`default_nettype none

module sss_correlator (
    input  logic                    clk_i,
    input  logic                    reset_ni,
    input  logic                    seq0_bit_i,
    input  logic                    seq0_valid_i,
    input  logic                    seq1_bit_i,
    input  logic                    seq1_valid_i,
    input  nr_sss_pkg::sss_frame_t  frame_i,
    input  logic                    frame_valid_i,
    input  logic [1:0]              n_id_2_i,
    input  logic                    n_id_2_valid_i,
    output logic                    busy_o,
    output nr_sss_pkg::sss_result_t result_o,
    output logic                    result_valid_o
);

    import nr_sss_pkg::*;

    localparam int unsigned      IDX_W    = $clog2(SSS_LEN);
    localparam int unsigned      ACC_W    = IDX_W + 1;
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(SSS_LEN - 1);
    // pos_q reaches SSS_LEN in the decision cycle, same value marks full stores
    localparam logic [IDX_W-1:0] IDX_END  = IDX_W'(SSS_LEN);
    localparam logic [IDX_W-1:0] M1_LAST  = IDX_W'(SHIFT_GROUP - 1);
    // m0 grows by 15 for every group of 112 hypotheses
    localparam logic [IDX_W-1:0] M0_STEP  = IDX_W'(15);

    sss_state_e              state_q;
    sss_frame_t              seq0_q;
    sss_frame_t              seq1_q;
    sss_frame_t              frame_q;
    logic [IDX_W-1:0]        fill_q;
    logic                    stores_full;
    logic                    frame_pending_q;
    logic                    start;
    logic [1:0]              n_id_2_q;
    logic [IDX_W-1:0]        m0_base;
    logic [IDX_W-1:0]        m0_q;
    logic [IDX_W-1:0]        m1_q;
    logic [IDX_W-1:0]        idx0_q;
    logic [IDX_W-1:0]        idx1_q;
    logic                    wrap0;
    logic                    wrap1;
    logic [IDX_W-1:0]        pos_q;
    logic [N_ID_1_W-1:0]     n_id_1_q;
    logic [N_ID_W-1:0]       n_id;
    logic signed [ACC_W-1:0] acc_q;
    logic [IDX_W-1:0]        acc_abs;
    logic [IDX_W-1:0]        best_abs_q;
    logic                    match;
    sss_result_t             best_q;
    sss_result_t             result_q;
    logic                    result_valid_q;

    assign busy_o         = (state_q != SSS_LOAD);
    assign result_o       = result_q;
    assign result_valid_o = result_valid_q;

    assign stores_full = (fill_q == IDX_END);
    assign start       = (frame_valid_i || frame_pending_q) && stores_full;

    // 5*N_id_2 without a multiplier
    always_comb begin
        unique case (n_id_2_q)
            2'd1:    m0_base = IDX_W'(5);
            2'd2:    m0_base = IDX_W'(10);
            default: m0_base = '0;
        endcase
    end

    // read pointers step through (n + m) mod 127
    assign wrap0 = (idx0_q == IDX_LAST);
    assign wrap1 = (idx1_q == IDX_LAST);

    // expected bit is the inverse of x0 xor x1, a match counts +1
    assign match   = (frame_q.bits[pos_q] == ~(seq0_q.bits[idx0_q] ^ seq1_q.bits[idx1_q]));
    assign acc_abs = acc_q[ACC_W-1] ? IDX_W'(-acc_q) : IDX_W'(acc_q);
    assign n_id    = (N_ID_W'(n_id_1_q) << 1) + N_ID_W'(n_id_1_q) + N_ID_W'(n_id_2_q);

    // sequences shift in from the top so x(0) ends up at bit 0
    always_ff @(posedge clk_i) begin
        if (seq0_valid_i) begin
            seq0_q.bits <= {seq0_bit_i, seq0_q.bits[SSS_LEN-1:1]};
        end
        if (seq1_valid_i) begin
            seq1_q.bits <= {seq1_bit_i, seq1_q.bits[SSS_LEN-1:1]};
        end
        if (state_q == SSS_LOAD && frame_valid_i) begin
            frame_q <= frame_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            fill_q <= '0;
        end else if (seq0_valid_i && seq1_valid_i && !stores_full) begin
            fill_q <= fill_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q         <= SSS_LOAD;
            frame_pending_q <= 1'b0;
            n_id_2_q        <= '0;
            m0_q            <= '0;
            m1_q            <= '0;
            idx0_q          <= '0;
            idx1_q          <= '0;
            pos_q           <= '0;
            n_id_1_q        <= '0;
            acc_q           <= '0;
            best_abs_q      <= '0;
            best_q          <= '0;
            result_q        <= '0;
            result_valid_q  <= 1'b0;
        end else begin
            result_valid_q <= 1'b0;
            unique case (state_q)
                SSS_LOAD: begin
                    if (n_id_2_valid_i) begin
                        n_id_2_q <= n_id_2_i;
                    end
                    if (start) begin
                        state_q         <= SSS_SEARCH;
                        frame_pending_q <= 1'b0;
                        m0_q            <= m0_base;
                        m1_q            <= '0;
                        idx0_q          <= m0_base;
                        idx1_q          <= '0;
                        pos_q           <= '0;
                        n_id_1_q        <= '0;
                        acc_q           <= '0;
                        best_abs_q      <= '0;
                    end else if (frame_valid_i) begin
                        // sequences still loading, search starts once they are in
                        frame_pending_q <= 1'b1;
                    end
                end
                SSS_SEARCH: begin
                    if (pos_q != IDX_END) begin
                        acc_q  <= match ? acc_q + 2'sd1 : acc_q - 2'sd1;
                        idx0_q <= wrap0 ? '0 : idx0_q + 1'b1;
                        idx1_q <= wrap1 ? '0 : idx1_q + 1'b1;
                        pos_q  <= pos_q + 1'b1;
                    end else begin
                        // decision cycle, strict increase keeps the earlier tie
                        if (acc_abs > best_abs_q) begin
                            best_abs_q    <= acc_abs;
                            best_q.n_id_1 <= n_id_1_q;
                            best_q.n_id   <= n_id;
                        end
                        acc_q <= '0;
                        pos_q <= '0;
                        if (n_id_1_q == N_ID_1_W'(N_ID_1_MAX)) begin
                            state_q <= SSS_REPORT;
                        end else begin
                            n_id_1_q <= n_id_1_q + 1'b1;
                            if (m1_q == M1_LAST) begin
                                // next group of 112
                                m0_q   <= m0_q + M0_STEP;
                                m1_q   <= '0;
                                idx0_q <= m0_q + M0_STEP;
                                idx1_q <= '0;
                            end else begin
                                m1_q   <= m1_q + 1'b1;
                                idx0_q <= m0_q;
                                idx1_q <= m1_q + 1'b1;
                            end
                        end
                    end
                end
                SSS_REPORT: begin
                    result_q       <= best_q;
                    result_valid_q <= 1'b1;
                    state_q        <= SSS_LOAD;
                end
                default: begin
                    state_q <= SSS_LOAD;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* tb_sss_model.svh */
`ifndef TB_SSS_MODEL_SVH
`define TB_SSS_MODEL_SVH

// x(i+7) = x(i+tap) + x(i) mod 2, started from x(0) = 1 and x(1..6) = 0
function automatic logic [SSS_LEN-1:0] build_mseq(input int tap);
    logic [SSS_LEN-1:0] x;
    x    = '0;
    x[0] = 1'b1;
    for (int i = 0; i + 7 < SSS_LEN; i++) begin
        x[i+7] = x[i+tap] ^ x[i];
    end
    return x;
endfunction

// reference SSS as bits, 1 for symbol +1
function automatic logic [SSS_LEN-1:0] build_sss(input int n_id_1, input int n_id_2);
    logic [SSS_LEN-1:0] x0;
    logic [SSS_LEN-1:0] x1;
    logic [SSS_LEN-1:0] d;
    int                 m0;
    int                 m1;
    x0 = build_mseq(4);
    x1 = build_mseq(1);
    m0 = 15 * (n_id_1 / 112) + 5 * n_id_2;
    m1 = n_id_1 % 112;
    for (int n = 0; n < SSS_LEN; n++) begin
        // product of two +-1 symbols is +1 when the bits agree
        d[n] = ~(x0[(n + m0) % SSS_LEN] ^ x1[(n + m1) % SSS_LEN]);
    end
    return d;
endfunction

// signed correlation of a received frame against one hypothesis
function automatic int correlate(input logic [SSS_LEN-1:0] rx, input int n_id_1,
                                 input int n_id_2);
    logic [SSS_LEN-1:0] ref_bits;
    int                 sum;
    ref_bits = build_sss(n_id_1, n_id_2);
    sum      = 0;
    for (int n = 0; n < SSS_LEN; n++) begin
        sum += (rx[n] == ref_bits[n]) ? 1 : -1;
    end
    return sum;
endfunction

// flips count distinct random positions
function automatic logic [SSS_LEN-1:0] flip_bits(input logic [SSS_LEN-1:0] frame,
                                                 input int count);
    logic [SSS_LEN-1:0] mask;
    int                 flipped;
    int                 pos;
    mask    = '0;
    flipped = 0;
    while (flipped < count) begin
        pos = $urandom % SSS_LEN;
        if (!mask[pos]) begin
            mask[pos] = 1'b1;
            flipped++;
        end
    end
    return frame ^ mask;
endfunction

`endif

/* tb_nr_sss_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_nr_sss_top;

    import nr_sss_pkg::*;

    `include "tb_sss_model.svh"

    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 10;
    localparam logic [31:0] SEED         = 32'hac65_f66c;
    // clean 5, inverted 1, noisy 1, busy_drop 2
    localparam int          DETECTIONS   = 9;
    localparam int          DETECT_CYCLES   = 336 * 128 + 300;
    localparam int          WATCHDOG_CYCLES = 2 * DETECTIONS * DETECT_CYCLES;

    logic        clk_i;
    logic        reset_ni;
    logic        sss_bit_i;
    logic        sss_valid_i;
    logic [1:0]  n_id_2_i;
    logic        n_id_2_valid_i;
    sss_result_t result_o;
    logic        result_valid_o;

    nr_sss_top dut0 (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .sss_bit_i     (sss_bit_i),
        .sss_valid_i   (sss_valid_i),
        .n_id_2_i      (n_id_2_i),
        .n_id_2_valid_i(n_id_2_valid_i),
        .result_o      (result_o),
        .result_valid_o(result_valid_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout: the DUT gave no result within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string test_name, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAIL %s: expected %0d, actual %0d", test_name, expected, actual);
            $display("Test failed");
            $fatal(1, "mismatch in %s", test_name);
        end
    endtask

    task automatic send_n_id_2(input int n_id_2);
        @(posedge clk_i);
        n_id_2_i       <= 2'(n_id_2);
        n_id_2_valid_i <= 1'b1;
        @(posedge clk_i);
        n_id_2_valid_i <= 1'b0;
    endtask

    task automatic send_frame(input logic [SSS_LEN-1:0] frame);
        for (int n = 0; n < SSS_LEN; n++) begin
            @(posedge clk_i);
            sss_bit_i   <= frame[n];
            sss_valid_i <= 1'b1;
        end
        @(posedge clk_i);
        sss_valid_i <= 1'b0;
    endtask

    task automatic wait_result(output sss_result_t res);
        @(posedge clk_i);
        while (!result_valid_o) begin
            @(posedge clk_i);
        end
        res = result_o;
    endtask

    // sends one cell, then checks the identity and the single-cycle strobe
    task automatic detect_cell(input string test_name, input logic [SSS_LEN-1:0] frame,
                               input int n_id_1, input int n_id_2);
        sss_result_t res;
        send_n_id_2(n_id_2);
        send_frame(frame);
        wait_result(res);
        check_value(test_name, n_id_1, int'(res.n_id_1));
        check_value(test_name, 3 * n_id_1 + n_id_2, int'(res.n_id));
        @(posedge clk_i);
        check_value(test_name, 0, int'(result_valid_o));
    endtask

    task automatic reset_state();
        repeat (200) begin
            @(posedge clk_i);
            check_value("reset_state", 0, int'(result_valid_o));
            check_value("reset_state", 0, int'(result_o));
        end
    endtask

    task automatic clean_detect();
        int n1_list[5];
        int n2_list[5];
        n1_list = '{0, 111, 112, 250, 335};
        n2_list = '{0, 1, 2, 0, 2};
        for (int i = 0; i < 5; i++) begin
            detect_cell("clean_detect", build_sss(n1_list[i], n2_list[i]),
                        n1_list[i], n2_list[i]);
        end
    endtask

    task automatic inverted_detect();
        detect_cell("inverted_detect", ~build_sss(77, 1), 77, 1);
    endtask

    task automatic noisy_detect();
        int                 n1;
        int                 n2;
        int                 c;
        int                 max_other;
        logic [SSS_LEN-1:0] noisy;
        n1    = $urandom % (N_ID_1_MAX + 1);
        n2    = $urandom % 3;
        noisy = flip_bits(build_sss(n1, n2), 20);
        // 20 errors leave 127 - 40 on the sent hypothesis
        check_value("noisy_detect", 87, correlate(noisy, n1, n2));
        max_other = 0;
        for (int k = 0; k <= N_ID_1_MAX; k++) begin
            if (k != n1) begin
                c = correlate(noisy, k, n2);
                if (c < 0) begin
                    c = -c;
                end
                if (c > max_other) begin
                    max_other = c;
                end
            end
        end
        check_value("noisy_detect", 1, (max_other < 87) ? 1 : 0);
        detect_cell("noisy_detect", noisy, n1, n2);
    endtask

    task automatic busy_drop();
        sss_result_t res;
        send_n_id_2(0);
        send_frame(build_sss(30, 0));
        // search is running by now
        repeat (5) @(posedge clk_i);
        for (int i = 0; i < 50; i++) begin
            @(posedge clk_i);
            sss_bit_i      <= 1'($urandom);
            sss_valid_i    <= 1'b1;
            n_id_2_i       <= 2'd2;
            n_id_2_valid_i <= (i == 10);
        end
        @(posedge clk_i);
        sss_valid_i    <= 1'b0;
        n_id_2_valid_i <= 1'b0;
        wait_result(res);
        // a latched N_id_2 of 2 would show up in n_id
        check_value("busy_drop", 30, int'(res.n_id_1));
        check_value("busy_drop", 90, int'(res.n_id));
        detect_cell("busy_drop", build_sss(200, 1), 200, 1);
    endtask

    initial begin
        clk_i          = 1'b0;
        reset_ni       = 1'b0;
        sss_bit_i      = 1'b0;
        sss_valid_i    = 1'b0;
        n_id_2_i       = 2'd0;
        n_id_2_valid_i = 1'b0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_ni <= 1'b1;
        reset_state();
        clean_detect();
        inverted_detect();
        noisy_detect();
        busy_drop();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
